// File: src/synctimer_pkg.sv
`default_nettype none

package synctimer_pkg;

    localparam int timer_width = 64;

    typedef logic [timer_width-1:0] time_t;  // ns units

    // clock period 10/3 ns
    localparam int step_num = 10;
    localparam int step_den = 3;

    localparam int step_int  = step_num / step_den;
    localparam int step_frac = step_num % step_den;

    // remainder accumulator holds 0 .. step_den-1
    localparam int frac_width = $clog2(step_den);

    typedef logic [frac_width-1:0] frac_t;
    typedef logic [frac_width:0]   frac_sum_t;  // one carry bit above frac_t

endpackage

`default_nettype wire

// File: src/etherneco_pkg.sv
`default_nettype none

package etherneco_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] offset_t;

    localparam byte_t node_id      = 8'h01;
    localparam byte_t cmd_override = 8'h10;  // load slave time
    localparam byte_t cmd_sync     = 8'h11;  // one unit nudge

    localparam offset_t sync_offset = 16'd16;  // link delay compensation

    // id, cmd, time, offset
    localparam int time_bytes = 8;
    localparam int packet_len = 2 + time_bytes + 2;

    localparam int fifo_depth = 16;

    typedef logic [$clog2(packet_len)-1:0] byte_cnt_t;
    typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;
    typedef logic [$clog2(fifo_depth):0]   fifo_cnt_t;

endpackage

`default_nettype wire

// File: src/byte_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

    etherneco_pkg::byte_t data;
    logic                 last;   // final byte of a packet
    logic                 valid;
    logic                 ready;

    modport source (
        output data, last, valid,
        input  ready
    );

    modport sink (
        input  data, last, valid,
        output ready
    );

endinterface

`default_nettype wire

// File: src/synctimer_timer.sv
`timescale 1ns/1ps
`default_nettype none

module synctimer_timer (
    input  logic                 clk,
    input  logic                 reset,
    input  synctimer_pkg::time_t set_time,
    input  logic                 set_valid,
    input  logic                 adjust_sign,   // high means minus
    input  logic                 adjust_valid,
    output logic                 adjust_ready,
    output synctimer_pkg::time_t current_time
);

    synctimer_pkg::frac_t     acc;
    synctimer_pkg::frac_sum_t acc_sum;
    synctimer_pkg::time_t     step;
    logic                     wrap;
    logic                     adj_pending;
    logic                     adj_minus;

    always_comb begin
        acc_sum = {1'b0, acc} + synctimer_pkg::frac_sum_t'(synctimer_pkg::step_frac);
        wrap    = acc_sum >= synctimer_pkg::frac_sum_t'(synctimer_pkg::step_den);
        step    = synctimer_pkg::time_t'(synctimer_pkg::step_int) + synctimer_pkg::time_t'(wrap);
        if (adj_pending) begin
            step = adj_minus ? step - 1'b1 : step + 1'b1;  // single unit correction
        end
    end

    assign adjust_ready = !adj_pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
            acc          <= '0;
            adj_pending  <= 1'b0;
            adj_minus    <= 1'b0;
        end else begin
            acc <= synctimer_pkg::frac_t'(wrap ?
                acc_sum - synctimer_pkg::frac_sum_t'(synctimer_pkg::step_den) : acc_sum);

            if (set_valid) begin
                current_time <= set_time;
            end else begin
                current_time <= current_time + step;
            end

            // pending adjust is consumed by the following step
            if (adjust_valid && adjust_ready) begin
                adj_pending <= 1'b1;
                adj_minus   <= adjust_sign;
            end else begin
                adj_pending <= 1'b0;
            end
        end
    end

    // caller must not load and adjust in the same cycle
    a_no_set_and_adjust: assert property (@(posedge clk) disable iff (reset)
        !(set_valid && adjust_valid));

endmodule

`default_nettype wire

// File: src/synctimer_master.sv
`timescale 1ns/1ps
`default_nettype none

module synctimer_master (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sync_start,
    input  logic                 sync_override,
    output logic                 busy,
    output synctimer_pkg::time_t current_time,
    byte_stream_if.source        tx
);

    etherneco_pkg::byte_t [etherneco_pkg::packet_len-1:0] data_sr;
    logic [etherneco_pkg::packet_len-1:0]                 last_sr;
    logic                                                 valid_q;
    logic                                                 start;

    assign start = sync_start && !valid_q;  // ignored while a packet is out

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (start) begin
            valid_q <= 1'b1;
        end else if (valid_q && tx.ready && tx.last) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            data_sr[0] <= etherneco_pkg::node_id;
            data_sr[1] <= sync_override ? etherneco_pkg::cmd_override : etherneco_pkg::cmd_sync;
            data_sr[etherneco_pkg::time_bytes+1:2] <= current_time;  // lsb first on the wire
            data_sr[etherneco_pkg::packet_len-1:etherneco_pkg::time_bytes+2] <=
                etherneco_pkg::sync_offset;
            last_sr <= {1'b1, {(etherneco_pkg::packet_len-1){1'b0}}};
        end else if (valid_q && tx.ready) begin
            data_sr <= data_sr >> 8;
            last_sr <= last_sr >> 1;
        end
    end

    assign tx.valid = valid_q;
    assign tx.data  = data_sr[0];
    assign tx.last  = last_sr[0];
    assign busy     = valid_q;

    // free running, never loaded or adjusted
    synctimer_timer u_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     ('0),
        .set_valid    (1'b0),
        .adjust_sign  (1'b0),
        .adjust_valid (1'b0),
        .adjust_ready (),
        .current_time (current_time)
    );

    // stream held while the link stalls
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        tx.valid && !tx.ready |=> tx.valid && $stable(tx.data) && $stable(tx.last));

endmodule

`default_nettype wire

// File: src/byte_stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_stream_fifo (
    input  logic        clk,
    input  logic        reset,
    byte_stream_if.sink   wr,
    byte_stream_if.source rd
);

    etherneco_pkg::byte_t      mem_data [etherneco_pkg::fifo_depth];
    logic                      mem_last [etherneco_pkg::fifo_depth];
    etherneco_pkg::fifo_ptr_t  wr_ptr;
    etherneco_pkg::fifo_ptr_t  rd_ptr;
    etherneco_pkg::fifo_cnt_t  count;
    logic                      full;
    logic                      empty;
    logic                      push;
    logic                      pop;
    logic                      out_valid;
    etherneco_pkg::byte_t      out_data;
    logic                      out_last;

    assign full  = count == etherneco_pkg::fifo_cnt_t'(etherneco_pkg::fifo_depth);
    assign empty = count == '0;
    assign push  = wr.valid && !full;
    assign pop   = !empty && (!out_valid || rd.ready);  // refill output stage

    assign wr.ready = !full;
    assign rd.valid = out_valid;
    assign rd.data  = out_data;
    assign rd.last  = out_last;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= wr.data;
            mem_last[wr_ptr] <= wr.last;
        end
        if (pop) begin
            out_data <= mem_data[rd_ptr];
            out_last <= mem_last[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + etherneco_pkg::fifo_cnt_t'(push) - etherneco_pkg::fifo_cnt_t'(pop);

            if (pop) begin
                out_valid <= 1'b1;
            end else if (rd.ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // full with nothing leaving must stay full, so no write slipped in
    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        full && !pop |=> full);

    // empty with nothing arriving must stay empty
    a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
        empty && !push |=> empty);

endmodule

`default_nettype wire

// File: src/synctimer_slave.sv
`timescale 1ns/1ps
`default_nettype none

module synctimer_slave (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hold,
    byte_stream_if.sink          rx,
    output synctimer_pkg::time_t current_time,
    output logic                 sync_done
);

    typedef enum logic [1:0] {st_idle, st_header, st_payload, st_drop} state_t;

    state_t                                                 state;
    etherneco_pkg::byte_cnt_t                               cnt;
    logic                                                   is_override;
    etherneco_pkg::byte_t [etherneco_pkg::time_bytes+1:0]   pay_sr;
    etherneco_pkg::byte_t [etherneco_pkg::time_bytes+1:0]   pay_next;
    synctimer_pkg::time_t                                   rx_time;
    etherneco_pkg::offset_t                                 rx_offset;
    synctimer_pkg::time_t                                   target;
    logic                                                   accept;
    logic                                                   pkt_end;
    logic                                                   set_valid;
    logic                                                   adjust_valid;
    logic                                                   adjust_sign;
    logic                                                   adjust_ready;

    assign rx.ready = !hold;
    assign accept   = rx.valid && rx.ready;

    // payload with the incoming byte already shifted in
    assign pay_next  = {rx.data, pay_sr[etherneco_pkg::time_bytes+1:1]};
    assign rx_time   = pay_next[etherneco_pkg::time_bytes-1:0];
    assign rx_offset = pay_next[etherneco_pkg::time_bytes+1:etherneco_pkg::time_bytes];
    assign target    = rx_time + synctimer_pkg::time_t'(rx_offset);

    assign pkt_end      = accept && rx.last && state == st_payload;
    assign set_valid    = pkt_end && is_override;
    assign adjust_valid = pkt_end && !is_override && adjust_ready && target != current_time;
    assign adjust_sign  = target < current_time;  // slave ahead, slow down

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            cnt       <= '0;
            sync_done <= 1'b0;
        end else begin
            sync_done <= pkt_end;
            if (accept) begin
                cnt <= rx.last ? '0 : cnt + 1'b1;
                case (state)
                    st_idle: begin
                        state <= (rx.data == etherneco_pkg::node_id) ? st_header : st_drop;
                    end
                    st_header: begin
                        state <= (rx.data == etherneco_pkg::cmd_override ||
                                  rx.data == etherneco_pkg::cmd_sync) ? st_payload : st_drop;
                    end
                    default: begin
                        if (rx.last) begin
                            state <= st_idle;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == st_header) begin
            is_override <= rx.data == etherneco_pkg::cmd_override;
        end
        if (accept && state == st_payload) begin
            pay_sr <= pay_next;
        end
    end

    synctimer_timer u_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     (target),
        .set_valid    (set_valid),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready),
        .current_time (current_time)
    );

    // framing from the master survives the FIFO
    a_last_position: assert property (@(posedge clk) disable iff (reset)
        accept && rx.last |-> cnt == etherneco_pkg::byte_cnt_t'(etherneco_pkg::packet_len - 1));

endmodule

`default_nettype wire

// File: src/synctimer_top.sv
`timescale 1ns/1ps
`default_nettype none

module synctimer_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sync_start,
    input  logic                 sync_override,
    input  logic                 rx_hold,
    output logic                 sync_busy,
    output logic                 sync_done,
    output synctimer_pkg::time_t master_time,
    output synctimer_pkg::time_t slave_time
);

    byte_stream_if link_tx ();  // master to fifo
    byte_stream_if link_rx ();  // fifo to slave

    synctimer_master u_master (
        .clk           (clk),
        .reset         (reset),
        .sync_start    (sync_start),
        .sync_override (sync_override),
        .busy          (sync_busy),
        .current_time  (master_time),
        .tx            (link_tx)
    );

    byte_stream_fifo u_fifo (
        .clk   (clk),
        .reset (reset),
        .wr    (link_tx),
        .rd    (link_rx)
    );

    synctimer_slave u_slave (
        .clk          (clk),
        .reset        (reset),
        .hold         (rx_hold),
        .rx           (link_rx),
        .current_time (slave_time),
        .sync_done    (sync_done)
    );

endmodule

`default_nettype wire

// File: tb/tb_synctimer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_synctimer;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       sync_start;
    logic                       sync_override;
    logic                       rx_hold;
    logic                       sync_busy;
    logic                       sync_done;
    synctimer_pkg::time_t       master_time;
    synctimer_pkg::time_t       slave_time;

    synctimer_pkg::time_t [2:0] m_hist;  // [0] is the previous sample
    synctimer_pkg::time_t [2:0] s_hist;
    logic [2:0]                 done_hist;
    logic signed [63:0]         m_step;
    logic signed [63:0]         s_step;
    logic signed [63:0]         m_win;
    logic signed [63:0]         s_win;
    int                         nom_step;
    synctimer_pkg::time_t       cap_time;
    synctimer_pkg::time_t       cap_target;
    logic                       cap_override;
    logic                       outstanding;
    logic                       start_taken;
    logic                       timed_out = 1'b0;
    int                         run_cycles;
    int                         adj_expect = 0;
    int                         error_count = 0;
    int                         tests_passed = 0;
    int                         tests_failed = 0;
    logic [15:0]                lfsr_state;

    synctimer_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .sync_start    (sync_start),
        .sync_override (sync_override),
        .rx_hold       (rx_hold),
        .sync_busy     (sync_busy),
        .sync_done     (sync_done),
        .master_time   (master_time),
        .slave_time    (slave_time)
    );

    always #4 clk = ~clk;

    assign start_taken = sync_start && !sync_busy && !reset;
    assign cap_target  = cap_time + synctimer_pkg::time_t'(etherneco_pkg::sync_offset);
    assign m_step      = master_time - m_hist[0];
    assign s_step      = slave_time - s_hist[0];
    assign m_win       = master_time - m_hist[2];
    assign s_win       = slave_time - s_hist[2];

    // nominal step of the last edge, time is floor(n * 10/3) after n steps
    assign nom_step = (run_cycles * synctimer_pkg::step_num) / synctimer_pkg::step_den -
        ((run_cycles - 1) * synctimer_pkg::step_num) / synctimer_pkg::step_den;

    // direction the slave should be nudged, from the sync rule
    function automatic int sign_of(input synctimer_pkg::time_t target,
                                   input synctimer_pkg::time_t now);
        if (target > now) begin
            return 1;
        end else if (target < now) begin
            return -1;
        end
        return 0;
    endfunction

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[6:0], fb};
        end
        return r;
    endfunction

    always @(posedge clk) begin
        m_hist    <= {m_hist[1:0], master_time};
        s_hist    <= {s_hist[1:0], slave_time};
        done_hist <= {done_hist[1:0], sync_done};
        run_cycles <= reset ? 0 : run_cycles + 1;
        if (sync_done) begin
            adj_expect <= sign_of(cap_target, s_hist[0]);  // slave time at acceptance
        end
        if (start_taken) begin
            cap_time     <= master_time;
            cap_override <= sync_override;
        end
        if (reset) begin
            outstanding <= 1'b0;
        end else if (start_taken) begin
            outstanding <= 1'b1;
        end else if (sync_done) begin
            outstanding <= 1'b0;
        end
    end

    a_master_step: assert property (@(posedge clk) disable iff (reset)
        run_cycles >= 1 |-> m_step == 3 || m_step == 4)
        else begin
            error_count++;
            $display("Mismatch at %0t: master_time step got %0d expected 3 or 4",
                $time, $sampled(m_step));
        end

    a_master_window: assert property (@(posedge clk) disable iff (reset)
        run_cycles >= 3 |-> m_win == 10)
        else begin
            error_count++;
            $display("Mismatch at %0t: master_time over 3 cycles got %0d expected 10",
                $time, $sampled(m_win));
        end

    a_slave_step: assert property (@(posedge clk) disable iff (reset)
        run_cycles >= 1 && !sync_done && !done_hist[0] |-> s_step == 3 || s_step == 4)
        else begin
            error_count++;
            $display("Mismatch at %0t: slave_time step got %0d expected 3 or 4",
                $time, $sampled(s_step));
        end

    // windows touching a load or an adjust are skipped
    a_slave_window: assert property (@(posedge clk) disable iff (reset)
        run_cycles >= 3 && !sync_done && done_hist == 3'b000 |-> s_win == 10)
        else begin
            error_count++;
            $display("Mismatch at %0t: slave_time over 3 cycles got %0d expected 10",
                $time, $sampled(s_win));
        end

    a_override: assert property (@(posedge clk) disable iff (reset)
        sync_done && cap_override |-> slave_time == cap_target)
        else begin
            error_count++;
            $display("Mismatch at %0t: slave_time got %0d expected %0d",
                $time, $sampled(slave_time), $sampled(cap_target));
        end

    a_adjust: assert property (@(posedge clk) disable iff (reset)
        done_hist[0] && !cap_override |-> s_step == nom_step + adj_expect)
        else begin
            error_count++;
            $display("Mismatch at %0t: slave_time step got %0d expected %0d",
                $time, $sampled(s_step), $sampled(nom_step) + $sampled(adj_expect));
        end

    a_one_done: assert property (@(posedge clk) disable iff (reset)
        sync_done |-> outstanding)
        else begin
            error_count++;
            $display("sync_done at %0t without an accepted sync_start", $time);
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        sync_done |=> !sync_done)
        else begin
            error_count++;
            $display("sync_done at %0t stayed high for more than one cycle", $time);
        end

    a_start_after_done: assert property (@(posedge clk) disable iff (reset)
        start_taken |-> !outstanding)
        else begin
            error_count++;
            $display("sync_start at %0t was taken before the previous sync_done", $time);
        end

    // called right after a rising edge
    task automatic run_sync(input logic ovr, input logic extra, input logic rand_hold);
        int   waited;
        int   gap;
        logic done_seen;
        waited    = 0;
        done_seen = 1'b0;
        if (!timed_out) begin
            sync_start    <= 1'b1;
            sync_override <= ovr;
            while (!done_seen && waited < 400) begin  // far above worst latency
                @(posedge clk);
                waited++;
                if (sync_done) begin
                    done_seen = 1'b1;
                end else begin
                    // extra pulses land inside the 12 cycles the packet is sent
                    sync_start <= extra && waited < 8 && (waited % 2 == 1);
                    if (rand_hold) begin
                        rx_hold <= rand_bits(1) != 8'd0;
                    end else begin
                        rx_hold <= 1'b0;
                    end
                end
            end
            sync_start <= 1'b0;
            rx_hold    <= 1'b0;
            if (!done_seen) begin
                error_count++;
                timed_out = 1'b1;
                $display("timeout at %0t: no sync_done within 400 cycles", $time);
            end else begin
                gap = 2 + int'(rand_bits(3));
                repeat (gap) @(posedge clk);
            end
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name,
                error_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        reset         = 1'b1;
        sync_start    = 1'b0;
        sync_override = 1'b0;
        rx_hold       = 1'b0;
        lfsr_state    = 16'd15;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        errs = error_count;
        repeat (40) @(posedge clk);
        finish_test(1, "timer rate", errs);

        errs = error_count;
        run_sync(1'b1, 1'b0, 1'b0);
        run_sync(1'b1, 1'b0, 1'b0);
        finish_test(2, "override sync", errs);

        errs = error_count;
        for (int i = 0; i < 3; i++) begin
            run_sync(1'b0, 1'b0, 1'b0);
        end
        finish_test(3, "adjust sync", errs);

        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            run_sync(rand_bits(1) != 8'd0, 1'b0, 1'b1);
        end
        finish_test(4, "back-pressure", errs);

        errs = error_count;
        for (int i = 0; i < 4; i++) begin
            run_sync(rand_bits(1) != 8'd0, 1'b1, 1'b1);
        end
        finish_test(5, "busy rule", errs);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
            tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/synctimer_pkg.sv
src/etherneco_pkg.sv
src/byte_stream_if.sv
src/synctimer_timer.sv
src/synctimer_master.sv
src/byte_stream_fifo.sv
src/synctimer_slave.sv
src/synctimer_top.sv
tb/tb_synctimer.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_synctimer
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
